//--- src/touch_pkg.sv
`default_nettype none

package touch_pkg;

    // Coordinate registers of the touch controller
    typedef enum logic [7:0] {
        XH = 8'h03,
        XL = 8'h04,
        YH = 8'h05,
        YL = 8'h06
    } reg_addr_t;

    // Bus level operations
    typedef enum logic [2:0] {
        BIT_NONE,
        BIT_START,
        BIT_STOP,
        BIT_WRITE,
        BIT_READ
    } bit_op_t;

    typedef struct packed {
        bit_op_t op;
        logic    sda;   // Line value for BIT_WRITE
    } bit_cmd_t;

    // BYTE_ACK is one write slot, SDA value taken from data[0]
    typedef enum logic [2:0] {
        BYTE_NONE,
        BYTE_START,
        BYTE_STOP,
        BYTE_WRITE,
        BYTE_READ,
        BYTE_ACK
    } byte_op_t;

    typedef struct packed {
        byte_op_t   op;
        logic [7:0] data;
    } byte_cmd_t;

    typedef struct packed {
        logic [7:0] x_hi;
        logic [7:0] x_lo;
        logic [7:0] y_hi;
        logic [7:0] y_lo;
    } coord_t;

    localparam int         PHASE_CYCLES_DEFAULT = 256;
    localparam logic [6:0] TOUCH_ADDR_DEFAULT   = 7'h38;

endpackage

`default_nettype wire

//--- src/bit_engine.sv
`timescale 1ns/1ns
`default_nettype none

module bit_engine
    import touch_pkg::*;
#(
    parameter int PHASE_CYCLES = PHASE_CYCLES_DEFAULT
) (
    input  logic     clk,
    input  logic     nRst,
    input  bit_cmd_t bit_cmd,
    input  logic     scl_in,
    input  logic     sda_in,
    output logic     bit_done,
    output logic     rx_bit,
    output logic     scl_out,
    output logic     sda_out
);

    localparam int CNT_W = (PHASE_CYCLES > 1) ? $clog2(PHASE_CYCLES) : 1;

    typedef enum logic [2:0] {
        S_IDLE,
        S_PH1,
        S_PH2,      // SCL high phase for write and read
        S_PH3,
        S_FINISH
    } state_t;

    state_t           state;
    bit_op_t          op_q;
    logic [CNT_W-1:0] cnt;
    logic             phase_end;

    assign phase_end = (cnt == CNT_W'(PHASE_CYCLES - 1));

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state    <= S_IDLE;
            op_q     <= BIT_NONE;
            cnt      <= '0;
            scl_out  <= 1'b1;
            sda_out  <= 1'b1;
            bit_done <= 1'b0;
            rx_bit   <= 1'b0;
        end else begin
            bit_done <= 1'b0;
            cnt      <= phase_end ? '0 : cnt + 1'b1;
            case (state)
                S_IDLE: begin
                    cnt <= '0;
                    if (bit_cmd.op != BIT_NONE) begin
                        op_q  <= bit_cmd.op;
                        state <= S_PH1;
                        case (bit_cmd.op)
                            BIT_WRITE: sda_out <= bit_cmd.sda;
                            BIT_READ:  sda_out <= 1'b1;   // Release for the slave
                            BIT_STOP:  sda_out <= 1'b0;
                            default:   ;
                        endcase
                    end
                end
                S_PH1: begin
                    if (phase_end) begin
                        state <= S_PH2;
                        if (op_q == BIT_START)
                            sda_out <= 1'b0;
                        else
                            scl_out <= 1'b1;
                    end
                end
                S_PH2: begin
                    if (phase_end) begin
                        case (op_q)
                            BIT_START: scl_out <= 1'b0;
                            BIT_STOP:  sda_out <= 1'b1;
                            BIT_READ: begin
                                rx_bit  <= sda_in;
                                scl_out <= 1'b0;
                            end
                            default: ;
                        endcase
                        // Slave stretching the clock, give it another high phase
                        if (op_q == BIT_WRITE && !scl_in)
                            state <= S_PH2;
                        else
                            state <= S_PH3;
                        if (op_q == BIT_WRITE && scl_in)
                            scl_out <= 1'b0;
                    end
                end
                S_PH3: begin
                    if (phase_end)
                        state <= S_FINISH;
                end
                default: begin
                    cnt      <= '0;
                    state    <= S_IDLE;
                    bit_done <= 1'b1;
                end
            endcase
        end
    end

    // Byte engine waits for bit_done before the next strobe
    assert property (@(posedge clk) disable iff (!nRst)
        bit_cmd.op != BIT_NONE |-> state == S_IDLE);

    // Start and stop never move both lines in one step
    assert property (@(posedge clk) disable iff (!nRst)
        (op_q == BIT_START || op_q == BIT_STOP) && $fell(scl_out) |-> $stable(sda_out));

endmodule

`default_nettype wire

//--- src/byte_engine.sv
`timescale 1ns/1ns
`default_nettype none

module byte_engine
    import touch_pkg::*;
(
    input  logic      clk,
    input  logic      nRst,
    input  byte_cmd_t byte_cmd,
    output logic      byte_done,
    output logic [7:0] rx_byte,
    output bit_cmd_t  bit_cmd,
    input  logic      bit_done,
    input  logic      rx_bit
);

    byte_op_t   op_q;
    logic [7:0] data_q;
    logic [2:0] bit_cnt;    // Shared by writer and reader
    logic       busy;
    logic       issue;
    logic       last_bit;

    assign last_bit = !(op_q == BYTE_WRITE || op_q == BYTE_READ) || bit_cnt == 3'd7;

    always_comb begin
        bit_cmd.op  = BIT_NONE;
        bit_cmd.sda = (op_q == BYTE_ACK) ? data_q[0] : data_q[3'd7 - bit_cnt];  // MSB first
        if (issue) begin
            case (op_q)
                BYTE_START:          bit_cmd.op = BIT_START;
                BYTE_STOP:           bit_cmd.op = BIT_STOP;
                BYTE_WRITE, BYTE_ACK: bit_cmd.op = BIT_WRITE;
                BYTE_READ:           bit_cmd.op = BIT_READ;
                default:             bit_cmd.op = BIT_NONE;
            endcase
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            op_q      <= BYTE_NONE;
            bit_cnt   <= 3'd0;
            busy      <= 1'b0;
            issue     <= 1'b0;
            byte_done <= 1'b0;
        end else begin
            issue     <= 1'b0;
            byte_done <= 1'b0;
            if (!busy) begin
                if (byte_cmd.op != BYTE_NONE) begin
                    op_q    <= byte_cmd.op;
                    bit_cnt <= 3'd0;
                    busy    <= 1'b1;
                    issue   <= 1'b1;
                end
            end else if (bit_done) begin
                if (last_bit) begin
                    busy      <= 1'b0;
                    byte_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 3'd1;
                    issue   <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && byte_cmd.op != BYTE_NONE)
            data_q <= byte_cmd.data;
        if (busy && bit_done && op_q == BYTE_READ)
            rx_byte <= {rx_byte[6:0], rx_bit};
    end

    assert property (@(posedge clk) disable iff (!nRst)
        byte_cmd.op != BYTE_NONE |-> !busy);

    // Counter only climbs within one byte and never wraps past 7
    assert property (@(posedge clk) disable iff (!nRst)
        busy && $past(busy) |-> bit_cnt >= $past(bit_cnt));

endmodule

`default_nettype wire

//--- src/touch_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module touch_sequencer
    import touch_pkg::*;
#(
    parameter logic [6:0] TOUCH_ADDR = TOUCH_ADDR_DEFAULT
) (
    input  logic       clk,
    input  logic       nRst,
    input  logic       inter,
    output byte_cmd_t  byte_cmd,
    input  logic       byte_done,
    input  logic [7:0] rx_byte,
    output coord_t     data_out,
    output logic       done
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_START1,
        S_ADDR_W,
        S_ACK1,
        S_REG,
        S_ACK2,
        S_STOP1,
        S_START2,
        S_ADDR_R,
        S_ACK3,
        S_READ,
        S_NACK,
        S_STOP2
    } state_t;

    state_t    state;
    state_t    next_state;
    reg_addr_t reg_q;
    byte_cmd_t cmd;
    logic      issue;
    logic      inter_q;

    assign done     = (state == S_IDLE);
    assign byte_cmd = issue ? cmd : byte_cmd_t'{op: BYTE_NONE, data: 8'h00};

    // Command for the current step and the step after it
    always_comb begin
        cmd        = byte_cmd_t'{op: BYTE_NONE, data: 8'hFF};
        next_state = state;
        case (state)
            S_START1: begin cmd.op = BYTE_START; next_state = S_ADDR_W; end
            S_ADDR_W: begin
                cmd.op     = BYTE_WRITE;
                cmd.data   = {TOUCH_ADDR, 1'b0};
                next_state = S_ACK1;
            end
            S_ACK1: begin cmd.op = BYTE_ACK; next_state = S_REG; end   // SDA released
            S_REG: begin
                cmd.op     = BYTE_WRITE;
                cmd.data   = reg_q;
                next_state = S_ACK2;
            end
            S_ACK2:   begin cmd.op = BYTE_ACK; next_state = S_STOP1; end
            S_STOP1:  begin cmd.op = BYTE_STOP; next_state = S_START2; end
            S_START2: begin cmd.op = BYTE_START; next_state = S_ADDR_R; end
            S_ADDR_R: begin
                cmd.op     = BYTE_WRITE;
                cmd.data   = {TOUCH_ADDR, 1'b1};
                next_state = S_ACK3;
            end
            S_ACK3: begin cmd.op = BYTE_ACK; next_state = S_READ; end
            S_READ: begin cmd.op = BYTE_READ; next_state = S_NACK; end
            S_NACK: begin cmd.op = BYTE_ACK; next_state = S_STOP2; end  // Master NACK
            S_STOP2: begin
                cmd.op     = BYTE_STOP;
                next_state = (reg_q == YL) ? S_IDLE : S_START1;
            end
            default: next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state    <= S_IDLE;
            reg_q    <= XH;
            issue    <= 1'b0;
            inter_q  <= 1'b0;
            data_out <= '0;
        end else begin
            issue   <= 1'b0;
            inter_q <= !inter;      // Interrupt is active low
            if (state == S_IDLE) begin
                if (inter_q) begin
                    inter_q <= 1'b0;
                    reg_q   <= XH;
                    state   <= S_START1;
                    issue   <= 1'b1;
                end
            end else if (byte_done) begin
                state <= next_state;
                issue <= (next_state != S_IDLE);
                if (state == S_STOP2 && next_state == S_START1)
                    reg_q <= reg_addr_t'(reg_q + 8'd1);
                if (state == S_READ) begin
                    case (reg_q)
                        XH:      data_out.x_hi <= rx_byte;
                        XL:      data_out.x_lo <= rx_byte;
                        YH:      data_out.y_hi <= rx_byte;
                        default: data_out.y_lo <= rx_byte;
                    endcase
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!nRst)
        $changed(data_out) |-> $past(byte_done && state == S_READ));

endmodule

`default_nettype wire

//--- src/touch_reader_top.sv
`timescale 1ns/1ns
`default_nettype none

module touch_reader_top
    import touch_pkg::*;
#(
    parameter int         PHASE_CYCLES = PHASE_CYCLES_DEFAULT,
    parameter logic [6:0] TOUCH_ADDR   = TOUCH_ADDR_DEFAULT
) (
    input  logic   clk,
    input  logic   nRst,
    input  logic   inter,
    input  logic   scl_in,
    input  logic   sda_in,
    output logic   scl_out,
    output logic   sda_out,
    output coord_t data_out,
    output logic   done
);

    byte_cmd_t  byte_cmd;
    logic       byte_done;
    logic [7:0] rx_byte;
    bit_cmd_t   bit_cmd;
    logic       bit_done;
    logic       rx_bit;

    touch_sequencer #(
        .TOUCH_ADDR (TOUCH_ADDR)
    ) u_touch_sequencer (
        .clk       (clk),
        .nRst      (nRst),
        .inter     (inter),
        .byte_cmd  (byte_cmd),
        .byte_done (byte_done),
        .rx_byte   (rx_byte),
        .data_out  (data_out),
        .done      (done)
    );

    byte_engine u_byte_engine (
        .clk       (clk),
        .nRst      (nRst),
        .byte_cmd  (byte_cmd),
        .byte_done (byte_done),
        .rx_byte   (rx_byte),
        .bit_cmd   (bit_cmd),
        .bit_done  (bit_done),
        .rx_bit    (rx_bit)
    );

    bit_engine #(
        .PHASE_CYCLES (PHASE_CYCLES)
    ) u_bit_engine (
        .clk      (clk),
        .nRst     (nRst),
        .bit_cmd  (bit_cmd),
        .scl_in   (scl_in),
        .sda_in   (sda_in),
        .bit_done (bit_done),
        .rx_bit   (rx_bit),
        .scl_out  (scl_out),
        .sda_out  (sda_out)
    );

endmodule

`default_nettype wire

//--- tb/touch_reader_tb.sv
`timescale 1ns/1ns
`default_nettype none

module touch_reader_tb
    import touch_pkg::*;
();

    localparam int CLK_NS      = 40;
    localparam int READ_LIMIT  = 5000;    // Cycles for one coordinate read
    localparam int WATCHDOG_NS = 6 * 4 * 40 * 16 * CLK_NS + 600000;

    localparam logic [1:0] EV_START = 2'd1;
    localparam logic [1:0] EV_STOP  = 2'd2;
    localparam logic [1:0] EV_FRAME = 2'd3;

    logic   clk;
    logic   nRst;
    logic   inter;
    logic   scl_in;
    logic   sda_in;
    logic   scl_out;
    logic   sda_out;
    coord_t data_out;
    logic   done;

    // Touch controller model
    logic [7:0]  regs [4];
    logic        slave_sda;
    logic        stretch_en;
    int          stretch_left;
    int          stretch_seen;
    logic        prev_scl;
    logic        prev_sda;
    logic        bus_sda;
    logic [8:0]  frame;
    int          bit_cnt;
    int          frame_idx;
    logic        is_read;
    logic [7:0]  reg_ptr;
    logic [10:0] bus_log [$];   // {event, frame bits}

    int          errors;
    int          tests;
    logic [31:0] lfsr;

    touch_reader_top #(
        .PHASE_CYCLES (4)
    ) u_touch_reader_top (
        .clk      (clk),
        .nRst     (nRst),
        .inter    (inter),
        .scl_in   (scl_in),
        .sda_in   (sda_in),
        .scl_out  (scl_out),
        .sda_out  (sda_out),
        .data_out (data_out),
        .done     (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("ERRORS FOUND");
        $finish;
    end

    // Slave and bus decoder, sampled just after each clock edge
    always @(posedge clk) begin
        #2;
        if (!nRst) begin
            prev_scl     = 1'b1;
            prev_sda     = 1'b1;
            slave_sda    = 1'b1;
            stretch_left = 0;
            bit_cnt      = 0;
            frame_idx    = 0;
            is_read      = 1'b0;
            scl_in       = 1'b1;
            sda_in       = 1'b1;
        end else begin
            bus_sda = sda_out & slave_sda;
            if (prev_scl && scl_out && prev_sda && !bus_sda) begin
                bus_log.push_back({EV_START, 9'h000});
                bit_cnt   = 0;
                frame_idx = 0;
                is_read   = 1'b0;
            end else if (prev_scl && scl_out && !prev_sda && bus_sda) begin
                bus_log.push_back({EV_STOP, 9'h000});
            end
            if (!prev_scl && scl_out) begin
                if (stretch_en && frame_idx == 0 && bit_cnt < 8) begin
                    stretch_left = 10;      // Address bits only
                    stretch_seen++;
                end
                frame = {frame[7:0], bus_sda};
                bit_cnt++;
                if (bit_cnt == 9) begin
                    bus_log.push_back({EV_FRAME, frame});
                    if (frame_idx == 0)
                        is_read = frame[1];
                    else if (!is_read)
                        reg_ptr = frame[8:1];
                    frame_idx++;
                    bit_cnt = 0;
                end
            end
            if (prev_scl && !scl_out) begin
                assert (scl_in) else begin
                    $display("scl_out fell at %0t while scl_in was held low", $time);
                    errors++;
                end
                if (is_read && frame_idx == 1 && bit_cnt < 8)
                    slave_sda = regs[2'(reg_ptr - 8'h03)][3'(7 - bit_cnt)];
                else
                    slave_sda = 1'b1;
            end
            if (stretch_left > 0) begin
                scl_in = 1'b0;
                stretch_left--;
            end else begin
                scl_in = scl_out;
            end
            sda_in   = sda_out & slave_sda;
            prev_scl = scl_out;
            prev_sda = bus_sda;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_byte(output logic [7:0] b);
        b = 8'h00;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_step(lfsr);
            b    = {b[6:0], lfsr[0]};
        end
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic wait_done(input logic level, input int limit);
        int cycles;
        cycles = 0;
        while (done !== level && cycles < limit) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        assert (done === level) else begin
            $display("done did not reach %0b within %0d cycles", level, limit);
            errors++;
        end
    endtask

    // Interrupt low to done low takes at most 3 cycles
    task automatic start_read(input logic hold);
        inter = 1'b0;
        @(posedge clk);
        #2;
        if (!hold)
            inter = 1'b1;
        wait_done(1'b0, 2);
    endtask

    task automatic check_coord();
        check_eq("data_out", data_out, {regs[0], regs[1], regs[2], regs[3]});
    endtask

    task automatic check_bus();
        logic [10:0] exp_q [$];
        for (int r = 0; r < 4; r++) begin
            exp_q.push_back({EV_START, 9'h000});
            exp_q.push_back({EV_FRAME, 8'h70, 1'b1});
            exp_q.push_back({EV_FRAME, 8'(8'h03 + r), 1'b1});
            exp_q.push_back({EV_STOP, 9'h000});
            exp_q.push_back({EV_START, 9'h000});
            exp_q.push_back({EV_FRAME, 8'h71, 1'b1});
            exp_q.push_back({EV_FRAME, regs[r], 1'b1});    // Master NACK
            exp_q.push_back({EV_STOP, 9'h000});
        end
        assert (bus_log.size() == exp_q.size()) else begin
            $display("Bus log holds %0d events instead of %0d", bus_log.size(), exp_q.size());
            errors++;
        end
        for (int i = 0; i < exp_q.size() && i < bus_log.size(); i++)
            check_eq($sformatf("bus event %0d", i), 32'(bus_log[i]), 32'(exp_q[i]));
    endtask

    task automatic report(input string name, input int err_before);
        tests++;
        $display("%s: %s", name, (errors == err_before) ? "pass" : "fail");
    endtask

    task automatic test_reset();
        int e;
        e = errors;
        check_eq("done", 32'(done), 32'd1);
        check_eq("scl_out", 32'(scl_out), 32'd1);
        check_eq("sda_out", 32'(sda_out), 32'd1);
        check_eq("data_out", data_out, 32'h0);
        report("reset state", e);
    endtask

    task automatic test_single_read();
        int e;
        e = errors;
        regs = '{8'h12, 8'h34, 8'h56, 8'h78};
        bus_log.delete();
        start_read(1'b0);
        wait_done(1'b1, READ_LIMIT);
        check_coord();
        check_bus();
        report("single read and bus order", e);
    endtask

    task automatic test_stretch();
        int e;
        e = errors;
        regs = '{8'hA5, 8'h3C, 8'hC3, 8'h5A};
        bus_log.delete();
        stretch_en   = 1'b1;
        stretch_seen = 0;
        start_read(1'b0);
        wait_done(1'b1, READ_LIMIT);
        stretch_en = 1'b0;
        check_coord();
        check_bus();
        assert (stretch_seen > 0) else begin
            $display("The slave never stretched the clock");
            errors++;
        end
        report("clock stretching", e);
    endtask

    task automatic test_random();
        int e;
        e = errors;
        for (int n = 0; n < 3; n++) begin
            for (int r = 0; r < 4; r++)
                random_byte(regs[r]);
            start_read(1'b0);
            wait_done(1'b1, READ_LIMIT);
            check_coord();
        end
        report("random values", e);
    endtask

    task automatic test_held_inter();
        int e;
        e = errors;
        for (int r = 0; r < 4; r++)
            random_byte(regs[r]);
        start_read(1'b1);
        wait_done(1'b1, READ_LIMIT);
        check_coord();
        wait_done(1'b0, 3);     // Second read from the held level
        inter = 1'b1;
        wait_done(1'b1, READ_LIMIT);
        check_coord();
        report("held interrupt", e);
    endtask

    initial begin
        errors     = 0;
        tests      = 0;
        lfsr       = 32'h7fec4c9d;
        nRst       = 1'b0;
        inter      = 1'b1;
        scl_in     = 1'b1;
        sda_in     = 1'b1;
        stretch_en = 1'b0;
        regs       = '{8'h00, 8'h00, 8'h00, 8'h00};
        repeat (8) @(posedge clk);
        #2;
        nRst = 1'b1;
        @(posedge clk);
        #2;
        test_reset();
        test_single_read();
        test_stretch();
        test_random();
        test_held_inter();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- touch_reader_top.f
src/touch_pkg.sv
src/bit_engine.sv
src/byte_engine.sv
src/touch_sequencer.sv
src/touch_reader_top.sv
tb/touch_reader_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := touch_reader_tb
FLIST     := touch_reader_top.f

SRCS      := $(shell cat $(FLIST))
BIN       := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
